// File: hdl/isaPkg.sv
// RV32 load/store type encodings and access width codes for the memory stage
// Encoding values match the execute stage decode; None means no access
package isaPkg;

    localparam int DataWidth = 32;          // Data word width
    localparam int AddrWidth = 32;          // Byte address width

    // Load type carried from execute to memory
    typedef enum logic [2:0] {
        LdNone = 3'd0,                      // No load
        LdLb   = 3'd1,                      // Signed byte
        LdLh   = 3'd2,                      // Signed half
        LdLw   = 3'd3,                      // Full word
        LdLbu  = 3'd4,                      // Unsigned byte
        LdLhu  = 3'd5                       // Unsigned half
    } ldType_t;

    // Store type carried from execute to memory
    typedef enum logic [1:0] {
        StNone = 2'd0,                      // No store
        StSb   = 2'd1,                      // Byte store
        StSh   = 2'd2,                      // Half store
        StSw   = 2'd3                       // Word store
    } stType_t;

    // Access width sent to the data cache
    typedef enum logic [1:0] {
        WidthByte = 2'd0,
        WidthHalf = 2'd1,
        WidthWord = 2'd2                    // Code 3 is unused
    } width_t;

endpackage

// File: hdl/memPkg.sv
// Lane and cache request bundles between execute, memory stage and data cache
// Depends on isaPkg, so it compiles after it
package memPkg;

    // One lane's execute-to-memory bundle, 69 bits
    typedef struct packed {
        isaPkg::ldType_t                 ldType;    // Load type, LdNone when idle
        isaPkg::stType_t                 stType;    // Store type, StNone when idle
        logic [isaPkg::DataWidth-1:0]    aluData;   // ALU result used as byte address
        logic [isaPkg::DataWidth-1:0]    rs2Data;   // Store data
    } laneReq_t;

    // Merged request into the data cache
    typedef struct packed {
        logic                            en;        // Some lane accesses memory
        logic                            rd;        // Some lane loads, blocks the write
        isaPkg::width_t                  width;     // Access width of the winning lane
        logic [isaPkg::AddrWidth-1:0]    addr;      // Byte address
        logic                            sign;      // Sign extend the loaded value
        logic [isaPkg::DataWidth-1:0]    wdata;     // Store data, low bits used
    } dcacheReq_t;

endpackage

// File: hdl/memStage.sv
// Purely combinational dual-lane memory stage where lane 0 wins the single cache port
// If both lanes load, both get the data at lane 0's address
`timescale 1ns/100ps

module memStage (
    input  memPkg::laneReq_t               lane0,       // Execute-to-memory lane 0
    input  memPkg::laneReq_t               lane1,       // Execute-to-memory lane 1
    input  logic                           memFlush,    // Pending CSR flush kills stores
    input  logic [isaPkg::DataWidth-1:0]   readData,    // From dcache
    output logic                           ldEn0,       // To forwarding logic
    output logic                           ldEn1,
    output logic                           accessEn0,   // Lane 0 uses memory this cycle
    output logic                           accessEn1,
    output memPkg::dcacheReq_t             dcacheReq,   // To dcache
    output logic [isaPkg::DataWidth-1:0]   loadData0,   // Load result per lane
    output logic [isaPkg::DataWidth-1:0]   loadData1
);

    memPkg::laneReq_t   lanes [2];                  // Lanes as an array for the decode loop
    logic [1:0]         isLd;                       // Lane loads
    logic [1:0]         isSt;                       // Lane stores
    logic [1:0]         isAcc;                      // Lane accesses memory after flush gating
    isaPkg::width_t     laneWidth [2];              // Decoded width per lane
    logic [1:0]         laneSign;                   // Decoded sign per lane

    // Width from the load type first, then the store type
    function automatic isaPkg::width_t decodeWidth(input memPkg::laneReq_t req);
        isaPkg::width_t w;
        if (req.ldType == isaPkg::LdLb || req.ldType == isaPkg::LdLbu) begin
            w = isaPkg::WidthByte;
        end else if (req.ldType == isaPkg::LdLh || req.ldType == isaPkg::LdLhu) begin
            w = isaPkg::WidthHalf;
        end else if (req.ldType == isaPkg::LdLw) begin
            w = isaPkg::WidthWord;
        end else if (req.stType == isaPkg::StSh) begin
            w = isaPkg::WidthHalf;
        end else if (req.stType == isaPkg::StSw) begin
            w = isaPkg::WidthWord;
        end else begin
            w = isaPkg::WidthByte;                  // Byte store or idle lane
        end
        return w;
    endfunction

    assign lanes[0] = lane0;
    assign lanes[1] = lane1;

    // Per-lane decode
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            isLd[i]      = (lanes[i].ldType != isaPkg::LdNone);
            isSt[i]      = (lanes[i].stType != isaPkg::StNone);
            isAcc[i]     = isLd[i] || (isSt[i] && !memFlush);  // Loads survive a flush
            laneWidth[i] = decodeWidth(lanes[i]);
            laneSign[i]  = (lanes[i].ldType == isaPkg::LdLb) ||
                           (lanes[i].ldType == isaPkg::LdLh);
        end
    end

    assign ldEn0     = isLd[0];
    assign ldEn1     = isLd[1];
    assign accessEn0 = isAcc[0];
    assign accessEn1 = isAcc[1];

    // Priority merge onto the one cache port
    always_comb begin
        dcacheReq.en = isAcc[0] || isAcc[1];
        dcacheReq.rd = isLd[0] || isLd[1];          // Any load turns the cycle into a read
        if (isAcc[0]) begin
            dcacheReq.width = laneWidth[0];
            dcacheReq.addr  = lane0.aluData;
            dcacheReq.sign  = laneSign[0];
        end else if (isAcc[1]) begin
            dcacheReq.width = laneWidth[1];
            dcacheReq.addr  = lane1.aluData;
            dcacheReq.sign  = laneSign[1];
        end else begin
            dcacheReq.width = isaPkg::WidthByte;    // Idle port sits at zero
            dcacheReq.addr  = '0;
            dcacheReq.sign  = 1'b0;
        end
        dcacheReq.wdata = isAcc[0] ? lane0.rs2Data : lane1.rs2Data;
    end

    // Read data steered only to loading lanes
    assign loadData0 = isLd[0] ? readData : '0;
    assign loadData1 = isLd[1] ? readData : '0;

endmodule

// File: hdl/dcache.sv
// Always-hit data RAM: combinational extended read, byte-enabled write on clk
// Addresses assumed naturally aligned; DcacheWords must be a power of two >= 2
// First reset cycle clears every word, later reset cycles sweep one word each
`timescale 1ns/100ps

module dcache #(
    parameter int DcacheWords = 256                 // Depth in 32-bit words
) (
    input  logic                           clk,
    input  logic                           rstN,        // Sync, active low
    input  memPkg::dcacheReq_t             dcacheReq,   // From memStage
    output logic [isaPkg::DataWidth-1:0]   readData     // Extended load result
);

    localparam int IdxWidth = $clog2(DcacheWords);

    logic [isaPkg::DataWidth-1:0]   mem [DcacheWords];  // Word array
    logic [IdxWidth-1:0]            wordIdx;            // Word index from addr[IdxWidth+1:2]
    logic [1:0]                     byteOff;            // Byte within word
    logic [3:0]                     byteEn;             // Store byte lanes
    logic [isaPkg::DataWidth-1:0]   wrData;             // Store data replicated onto lanes
    logic                           wrEn;
    logic [isaPkg::DataWidth-1:0]   rdWord;
    logic [isaPkg::DataWidth-1:0]   rdShift;            // Addressed byte/half moved to bit 0
    logic                           inRst;              // Previous cycle was in reset
    logic [IdxWidth-1:0]            clrIdx;             // Reset sweep pointer

    assign wordIdx = dcacheReq.addr[IdxWidth+1:2];      // Upper address bits ignored
    assign byteOff = dcacheReq.addr[1:0];
    assign wrEn    = dcacheReq.en && !dcacheReq.rd;

    // Byte enables and lane-replicated write data
    always_comb begin
        case (dcacheReq.width)
            isaPkg::WidthByte: begin
                byteEn = 4'b0001 << byteOff;
                wrData = {4{dcacheReq.wdata[7:0]}};
            end
            isaPkg::WidthHalf: begin
                byteEn = 4'b0011 << byteOff;        // Offset is 0 or 2
                wrData = {2{dcacheReq.wdata[15:0]}};
            end
            isaPkg::WidthWord: begin
                byteEn = 4'b1111;
                wrData = dcacheReq.wdata;
            end
            default: begin
                byteEn = 4'b0000;                   // Reserved width writes nothing
                wrData = dcacheReq.wdata;
            end
        endcase
    end

    // RAM write and reset clear
    always_ff @(posedge clk) begin
        inRst <= !rstN;
        if (!rstN) begin
            if (inRst) begin
                mem[clrIdx] <= '0;                  // Sweep one word
                clrIdx      <= clrIdx + 1'b1;
            end else begin
                for (int i = 0; i < DcacheWords; i++) begin
                    mem[i] <= '0;                   // Clear-all pass on reset entry
                end
                clrIdx <= '0;
            end
        end else if (wrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    mem[wordIdx][8*b +: 8] <= wrData[8*b +: 8];
                end
            end
        end
    end

    // Combinational read with extension
    assign rdWord  = mem[wordIdx];
    assign rdShift = rdWord >> {byteOff, 3'b000};

    always_comb begin
        case (dcacheReq.width)
            isaPkg::WidthByte: readData = {{(isaPkg::DataWidth-8){dcacheReq.sign & rdShift[7]}},
                                           rdShift[7:0]};
            isaPkg::WidthHalf: readData = {{(isaPkg::DataWidth-16){dcacheReq.sign & rdShift[15]}},
                                           rdShift[15:0]};
            default:           readData = rdWord;   // Word, no shift
        endcase
    end

endmodule

// File: hdl/memSubsystem.sv
// Memory stage plus always-hit data cache, one shared cache port
// All outputs combinational; stores land on the next rising clk edge
`timescale 1ns/100ps

module memSubsystem #(
    parameter int DcacheWords = 256                 // Data RAM depth in words
) (
    input  logic                           clk,
    input  logic                           rstN,        // Sync, active low
    input  memPkg::laneReq_t               lane0,
    input  memPkg::laneReq_t               lane1,
    input  logic                           memFlush,    // Blocks stores, not loads
    output logic                           ldEn0,
    output logic                           ldEn1,
    output logic                           accessEn0,
    output logic                           accessEn1,
    output logic [isaPkg::DataWidth-1:0]   loadData0,
    output logic [isaPkg::DataWidth-1:0]   loadData1
);

    memPkg::dcacheReq_t             dcacheReq;      // Stage to cache
    logic [isaPkg::DataWidth-1:0]   readData;       // Cache to stage

    memStage memStage_inst (
        .lane0     (lane0),
        .lane1     (lane1),
        .memFlush  (memFlush),
        .readData  (readData),
        .ldEn0     (ldEn0),
        .ldEn1     (ldEn1),
        .accessEn0 (accessEn0),
        .accessEn1 (accessEn1),
        .dcacheReq (dcacheReq),
        .loadData0 (loadData0),
        .loadData1 (loadData1)
    );

    dcache #(
        .DcacheWords (DcacheWords)
    ) dcache_inst (
        .clk       (clk),
        .rstN      (rstN),
        .dcacheReq (dcacheReq),
        .readData  (readData)
    );

endmodule

// File: sim/memSubsystemTb.sv
// Testbench for memSubsystem with a 64-word data RAM and seeded random lane traffic
// Inputs change on the falling edge and outputs are checked 1 ns later against a shadow model
// Random addresses are aligned to the access width and stay inside the RAM depth
`timescale 1ns/100ps

module memSubsystemTb;

    localparam int Words        = 64;           // RAM depth given to the DUT
    localparam int RandomCycles = 2000;
    localparam int MaxCycles    = 3000;         // Directed phases plus random run plus margin

    // Hand-worked results for the pattern word 32'hF08A_7F15
    localparam logic [31:0] PatWord = 32'hF08A_7F15;
    localparam logic [31:0] ExpLb  [4] = '{32'h0000_0015, 32'h0000_007F,
                                           32'hFFFF_FF8A, 32'hFFFF_FFF0};
    localparam logic [31:0] ExpLbu [4] = '{32'h0000_0015, 32'h0000_007F,
                                           32'h0000_008A, 32'h0000_00F0};
    localparam logic [31:0] ExpLh  [2] = '{32'h0000_7F15, 32'hFFFF_F08A};
    localparam logic [31:0] ExpLhu [2] = '{32'h0000_7F15, 32'h0000_F08A};

    logic               clk;
    logic               rstN;
    memPkg::laneReq_t   lane0;
    memPkg::laneReq_t   lane1;
    logic               memFlush;
    logic               ldEn0;
    logic               ldEn1;
    logic               accessEn0;
    logic               accessEn1;
    logic [31:0]        loadData0;
    logic [31:0]        loadData1;

    logic [31:0]        shadow [Words];         // Reference copy of the RAM
    integer             seed;
    int                 cycleCount = 0;

    memSubsystem #(
        .DcacheWords (Words)
    ) memSubsystem_inst (
        .clk       (clk),
        .rstN      (rstN),
        .lane0     (lane0),
        .lane1     (lane1),
        .memFlush  (memFlush),
        .ldEn0     (ldEn0),
        .ldEn1     (ldEn1),
        .accessEn0 (accessEn0),
        .accessEn1 (accessEn1),
        .loadData0 (loadData0),
        .loadData1 (loadData1)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            $display("sim failed");
            $fatal(1, "Timeout: test did not finish within %0d clock cycles", MaxCycles);
        end
    end

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string label);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, label, actual, expected);
            $display("sim failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    function automatic logic isLoad(input memPkg::laneReq_t r);
        return r.ldType != isaPkg::LdNone;
    endfunction

    function automatic logic isStore(input memPkg::laneReq_t r);
        return r.stType != isaPkg::StNone;
    endfunction

    function automatic logic usesMemory(input memPkg::laneReq_t r, input logic flush);
        return isLoad(r) || (isStore(r) && !flush);   // Flush only kills stores
    endfunction

    // Access size in bytes with the load type looked at first
    function automatic int accessBytes(input memPkg::laneReq_t r);
        int n;
        n = 1;
        if (r.ldType == isaPkg::LdLh || r.ldType == isaPkg::LdLhu) begin
            n = 2;
        end else if (r.ldType == isaPkg::LdLw) begin
            n = 4;
        end else if (!isLoad(r) && r.stType == isaPkg::StSh) begin
            n = 2;
        end else if (!isLoad(r) && r.stType == isaPkg::StSw) begin
            n = 4;
        end
        return n;
    endfunction

    // Value the cache returns for the winning lane
    function automatic logic [31:0] expectedRead(input memPkg::laneReq_t w);
        logic [31:0]    word;
        logic [31:0]    value;
        int             off;
        int             n;
        logic           sgn;
        word  = shadow[int'((w.aluData >> 2) % Words)];    // Upper address bits ignored
        off   = int'(w.aluData[1:0]);
        n     = accessBytes(w);
        sgn   = (w.ldType == isaPkg::LdLb) || (w.ldType == isaPkg::LdLh);
        value = word;
        if (n == 1) begin
            value = {{24{sgn & word[8*off+7]}}, word[8*off +: 8]};
        end else if (n == 2) begin
            value = {{16{sgn & word[8*off+15]}}, word[8*off +: 16]};
        end
        return value;
    endfunction

    // Shadow RAM update on each rising edge
    task automatic applyStore();
        memPkg::laneReq_t   w;
        logic               anyAcc;
        logic               anyLd;
        int                 idx;
        int                 off;
        int                 n;
        if (!rstN) begin
            for (int i = 0; i < Words; i++) begin
                shadow[i] = '0;
            end
        end else begin
            anyAcc = usesMemory(lane0, memFlush) || usesMemory(lane1, memFlush);
            anyLd  = isLoad(lane0) || isLoad(lane1);
            if (anyAcc && !anyLd) begin         // Any load in the cycle blocks the write
                w   = usesMemory(lane0, memFlush) ? lane0 : lane1;
                idx = int'((w.aluData >> 2) % Words);
                off = int'(w.aluData[1:0]);
                n   = accessBytes(w);
                for (int b = 0; b < n; b++) begin
                    shadow[idx][8*(off+b) +: 8] = w.rs2Data[8*b +: 8];
                end
            end
        end
    endtask

    always @(posedge clk) applyStore();

    task automatic checkOutputs();
        logic           ld0;
        logic           ld1;
        logic           acc0;
        logic           acc1;
        logic [31:0]    rdExp;
        ld0   = isLoad(lane0);
        ld1   = isLoad(lane1);
        acc0  = usesMemory(lane0, memFlush);
        acc1  = usesMemory(lane1, memFlush);
        rdExp = expectedRead(acc0 ? lane0 : lane1);   // Lane 0 owns the port when active
        checkEq(ldEn0, ld0, "ldEn0");
        checkEq(ldEn1, ld1, "ldEn1");
        checkEq(accessEn0, acc0, "accessEn0");
        checkEq(accessEn1, acc1, "accessEn1");
        checkEq(loadData0, ld0 ? rdExp : 32'h0, "loadData0");
        checkEq(loadData1, ld1 ? rdExp : 32'h0, "loadData1");
    endtask

    function automatic memPkg::laneReq_t idleLane();
        memPkg::laneReq_t r;
        r.ldType  = isaPkg::LdNone;
        r.stType  = isaPkg::StNone;
        r.aluData = '0;
        r.rs2Data = '0;
        return r;
    endfunction

    function automatic memPkg::laneReq_t loadLane(input isaPkg::ldType_t t,
                                                  input logic [31:0] addr);
        memPkg::laneReq_t r;
        r         = idleLane();
        r.ldType  = t;
        r.aluData = addr;
        return r;
    endfunction

    function automatic memPkg::laneReq_t storeLane(input isaPkg::stType_t t,
                                                   input logic [31:0] addr,
                                                   input logic [31:0] data);
        memPkg::laneReq_t r;
        r         = idleLane();
        r.stType  = t;
        r.aluData = addr;
        r.rs2Data = data;
        return r;
    endfunction

    // Drive one cycle on the falling edge and check once settled
    task automatic driveCycle(input memPkg::laneReq_t l0, input memPkg::laneReq_t l1,
                              input logic flush);
        @(negedge clk);
        lane0    = l0;
        lane1    = l1;
        memFlush = flush;
        #1;
        checkOutputs();
    endtask

    // Half idle, quarter loads, quarter stores
    task automatic randomLane(output memPkg::laneReq_t r);
        int             kind;
        int             sel;
        logic [31:0]    addr;
        kind      = $unsigned($random(seed)) % 8;
        addr      = $unsigned($random(seed)) % (Words * 4);
        r         = idleLane();
        r.rs2Data = $random(seed);
        if (kind == 4 || kind == 5) begin
            sel = $unsigned($random(seed)) % 5;
            case (sel)
                0:       r.ldType = isaPkg::LdLb;
                1:       r.ldType = isaPkg::LdLbu;
                2:       r.ldType = isaPkg::LdLh;
                3:       r.ldType = isaPkg::LdLhu;
                default: r.ldType = isaPkg::LdLw;
            endcase
        end else if (kind >= 6) begin
            sel = $unsigned($random(seed)) % 3;
            case (sel)
                0:       r.stType = isaPkg::StSb;
                1:       r.stType = isaPkg::StSh;
                default: r.stType = isaPkg::StSw;
            endcase
        end
        r.aluData = addr - (addr % accessBytes(r));    // Natural alignment
    endtask

    initial begin
        memPkg::laneReq_t   rnd0;
        memPkg::laneReq_t   rnd1;
        logic               rndFlush;
        rstN     = 1'b0;
        lane0    = idleLane();
        lane1    = idleLane();
        memFlush = 1'b0;
        seed     = 32'ha4f4_b0cf;
        repeat (4) @(posedge clk);              // Four rising edges in reset
        @(negedge clk);
        rstN = 1'b1;

        // Idle outputs and a cleared RAM
        driveCycle(idleLane(), idleLane(), 1'b0);
        for (int i = 0; i < Words; i++) begin
            driveCycle(loadLane(isaPkg::LdLw, 32'(i * 4)), idleLane(), 1'b0);
            checkEq(loadData0, 32'h0, "word after reset");
        end

        // Single-lane stores of each width read back as words
        driveCycle(storeLane(isaPkg::StSw, 32'h40, 32'h1122_3344), idleLane(), 1'b0);
        driveCycle(loadLane(isaPkg::LdLw, 32'h40), idleLane(), 1'b0);
        checkEq(loadData0, 32'h1122_3344, "SW readback");
        driveCycle(idleLane(), storeLane(isaPkg::StSb, 32'h41, 32'h5555_55AB), 1'b0);
        driveCycle(idleLane(), loadLane(isaPkg::LdLw, 32'h40), 1'b0);
        checkEq(loadData1, 32'h1122_AB44, "SB offset 1 readback");
        driveCycle(idleLane(), storeLane(isaPkg::StSh, 32'h42, 32'hFFFF_C0DE), 1'b0);
        driveCycle(loadLane(isaPkg::LdLw, 32'h40), idleLane(), 1'b0);
        checkEq(loadData0, 32'hC0DE_AB44, "SH offset 2 readback");
        driveCycle(storeLane(isaPkg::StSb, 32'h43, 32'h1234_5680), idleLane(), 1'b0);
        driveCycle(loadLane(isaPkg::LdLw, 32'h40), idleLane(), 1'b0);
        checkEq(loadData0, 32'h80DE_AB44, "SB offset 3 readback");

        // Sub-word loads at every offset
        driveCycle(storeLane(isaPkg::StSw, 32'h80, PatWord), idleLane(), 1'b0);
        for (int off = 0; off < 4; off++) begin
            driveCycle(idleLane(), loadLane(isaPkg::LdLb, 32'(32'h80 + off)), 1'b0);
            checkEq(loadData1, ExpLb[off], "LB");
            driveCycle(loadLane(isaPkg::LdLbu, 32'(32'h80 + off)), idleLane(), 1'b0);
            checkEq(loadData0, ExpLbu[off], "LBU");
        end
        for (int h = 0; h < 2; h++) begin
            driveCycle(loadLane(isaPkg::LdLh, 32'(32'h80 + 2 * h)), idleLane(), 1'b0);
            checkEq(loadData0, ExpLh[h], "LH");
            driveCycle(idleLane(), loadLane(isaPkg::LdLhu, 32'(32'h80 + 2 * h)), 1'b0);
            checkEq(loadData1, ExpLhu[h], "LHU");
        end

        // Both lanes active with lane 0 owning address and width
        driveCycle(loadLane(isaPkg::LdLw, 32'h80), loadLane(isaPkg::LdLbu, 32'h41), 1'b0);
        checkEq(loadData1, PatWord, "lane 1 shares lane 0 word");
        driveCycle(loadLane(isaPkg::LdLb, 32'h82), loadLane(isaPkg::LdLw, 32'h40), 1'b0);
        checkEq(loadData1, 32'hFFFF_FF8A, "lane 1 shares lane 0 byte");
        driveCycle(loadLane(isaPkg::LdLw, 32'h40),
                   storeLane(isaPkg::StSw, 32'h44, 32'hDEAD_BEEF), 1'b0);
        checkEq(loadData0, 32'h80DE_AB44, "load beside lane 1 store");
        driveCycle(idleLane(), loadLane(isaPkg::LdLw, 32'h44), 1'b0);
        checkEq(loadData1, 32'h0, "lane 1 store blocked by load");
        driveCycle(storeLane(isaPkg::StSw, 32'h48, 32'h1234_5678),
                   storeLane(isaPkg::StSw, 32'h4C, 32'h9999_9999), 1'b0);
        driveCycle(loadLane(isaPkg::LdLw, 32'h48), idleLane(), 1'b0);
        checkEq(loadData0, 32'h1234_5678, "lane 0 store wins");
        driveCycle(idleLane(), loadLane(isaPkg::LdLw, 32'h4C), 1'b0);
        checkEq(loadData1, 32'h0, "lane 1 store lost");

        // Flush kills stores but loads are still served
        driveCycle(storeLane(isaPkg::StSw, 32'h50, 32'hCAFE_F00D), idleLane(), 1'b1);
        checkEq(accessEn0, 1'b0, "flushed store access");
        driveCycle(idleLane(), storeLane(isaPkg::StSb, 32'h51, 32'h0000_0077), 1'b1);
        checkEq(accessEn1, 1'b0, "flushed byte store access");
        driveCycle(loadLane(isaPkg::LdLw, 32'h50), idleLane(), 1'b1);
        checkEq(accessEn0, 1'b1, "load under flush");
        checkEq(loadData0, 32'h0, "flushed stores left word");
        driveCycle(storeLane(isaPkg::StSw, 32'h40, 32'h0), loadLane(isaPkg::LdLw, 32'h40), 1'b1);
        checkEq(loadData1, 32'h80DE_AB44, "lane 1 load past flushed lane 0");

        // Random traffic against the model
        repeat (RandomCycles) begin
            randomLane(rnd0);
            randomLane(rnd1);
            rndFlush = ($unsigned($random(seed)) % 8) == 0;
            driveCycle(rnd0, rnd1, rndFlush);
        end

        @(negedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

// File: all.f
hdl/isaPkg.sv
hdl/memPkg.sv
hdl/memStage.sv
hdl/dcache.sv
hdl/memSubsystem.sv
sim/memSubsystemTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the memSubsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=memSubsystemSim

verilator --binary --timing -Wno-fatal -f all.f --top-module memSubsystemTb -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "sim passed" "$LOG"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi
